//--- design/rvPkg.sv
`default_nettype none

package rvPkg;

    typedef logic [31:0] wordT;                 // data, address and instruction word

    // major opcodes, instr[6:0]
    typedef enum logic [6:0] {
        OpImm    = 7'b0010011,                  // addi .. srai
        OpReg    = 7'b0110011,                  // add .. and
        OpLui    = 7'b0110111,
        OpAuipc  = 7'b0010111,
        OpBranch = 7'b1100011,                  // beq .. bgeu
        OpLoad   = 7'b0000011,                  // lb .. lhu
        OpStore  = 7'b0100011,                  // sb, sh, sw
        OpJal    = 7'b1101111,
        OpJalr   = 7'b1100111                   // i-type layout
    } opcodeT;

    typedef enum logic [2:0] {
        ImmI = 3'd0,                            // alu imm, loads, jalr
        ImmS = 3'd1,                            // stores
        ImmB = 3'd2,                            // branch offset
        ImmU = 3'd3,                            // lui, auipc
        ImmJ = 3'd4                             // jal offset
    } immSelT;

    typedef enum logic [3:0] {
        AluAdd   = 4'd0,
        AluSub   = 4'd1,                        // also branch compare
        AluSll   = 4'd2,
        AluSlt   = 4'd3,
        AluSltu  = 4'd4,
        AluXor   = 4'd5,
        AluSrl   = 4'd6,
        AluSra   = 4'd7,
        AluOr    = 4'd8,
        AluAnd   = 4'd9,
        AluPassB = 4'd10                        // lui passes imm through
    } aluOpT;

    typedef enum logic [1:0] {
        ResAlu     = 2'd0,
        ResLoad    = 2'd1,
        ResPcPlus4 = 2'd2                       // link value for jal/jalr
    } resultSelT;

    typedef enum logic [1:0] {
        PcPlus4  = 2'd0,
        PcTarget = 2'd1,                        // pc + imm, taken branch or jal
        PcJalr   = 2'd2                         // rs1 + imm, bit 0 cleared
    } pcSelT;

endpackage

`default_nettype wire

//--- design/controlDecoder.sv
`timescale 1ns/100ps
`default_nettype none

module controlDecoder (
    input  rvPkg::wordT      instr,
    input  logic             branchTaken,   // compare result from the alu
    output logic             regWrite,
    output logic             memWrite,
    output rvPkg::aluOpT     aluOp,
    output logic             aluSrcImm,     // opB from immediate
    output logic             aluSrcPc,      // opA from pc, auipc only
    output rvPkg::immSelT    immSel,
    output rvPkg::resultSelT resultSel,
    output rvPkg::pcSelT     pcSel
);
    import rvPkg::*;

    opcodeT     opcode;
    logic [2:0] func3;
    logic       func7Alt;                   // instr[30], sub and sra
    aluOpT      arithOp;                    // alu op for OpImm / OpReg
    pcSelT      pcReq;                      // pc source before branch flag

    assign opcode   = opcodeT'(instr[6:0]);
    assign func3    = instr[14:12];
    assign func7Alt = instr[30];

    // func3 picks the operation, func7 bit 5 the variant
    always_comb begin
        case (func3)
            3'b000:  arithOp = (opcode == OpReg && func7Alt) ? AluSub : AluAdd; // no subi
            3'b001:  arithOp = AluSll;
            3'b010:  arithOp = AluSlt;
            3'b011:  arithOp = AluSltu;
            3'b100:  arithOp = AluXor;
            3'b101:  arithOp = func7Alt ? AluSra : AluSrl; // srai uses the same bit
            3'b110:  arithOp = AluOr;
            default: arithOp = AluAnd;
        endcase
    end

    always_comb begin
        regWrite  = 1'b0;                   // unknown opcodes retire as no-ops
        memWrite  = 1'b0;
        aluOp     = AluAdd;
        aluSrcImm = 1'b0;
        aluSrcPc  = 1'b0;
        immSel    = ImmI;
        resultSel = ResAlu;
        pcReq     = PcPlus4;
        case (opcode)
            OpImm: begin
                regWrite  = 1'b1;
                aluOp     = arithOp;
                aluSrcImm = 1'b1;
            end
            OpReg: begin
                regWrite  = 1'b1;
                aluOp     = arithOp;        // rs1 op rs2
            end
            OpLui: begin
                regWrite  = 1'b1;
                aluOp     = AluPassB;       // rd = imm
                aluSrcImm = 1'b1;
                immSel    = ImmU;
            end
            OpAuipc: begin
                regWrite  = 1'b1;           // rd = pc + imm, no redirect
                aluSrcImm = 1'b1;
                aluSrcPc  = 1'b1;
                immSel    = ImmU;
            end
            OpBranch: begin
                aluOp     = AluSub;
                immSel    = ImmB;
                pcReq     = PcTarget;       // qualified by branchTaken below
            end
            OpLoad: begin
                regWrite  = 1'b1;
                aluSrcImm = 1'b1;           // address = rs1 + imm
                resultSel = ResLoad;
            end
            OpStore: begin
                memWrite  = 1'b1;
                aluSrcImm = 1'b1;
                immSel    = ImmS;
            end
            OpJal: begin
                regWrite  = 1'b1;
                immSel    = ImmJ;
                resultSel = ResPcPlus4;     // link
                pcReq     = PcTarget;
            end
            OpJalr: begin
                regWrite  = 1'b1;
                aluSrcImm = 1'b1;
                resultSel = ResPcPlus4;
                pcReq     = PcJalr;         // target formed in pcUnit
            end
            default: begin
            end
        endcase
    end

    // branch falls through when the compare fails
    assign pcSel = (opcode == OpBranch && !branchTaken) ? PcPlus4 : pcReq;

endmodule

`default_nettype wire

//--- design/immExtend.sv
`timescale 1ns/100ps
`default_nettype none

module immExtend (
    input  rvPkg::wordT   instr,
    input  rvPkg::immSelT immSel,
    output rvPkg::wordT   imm
);
    import rvPkg::*;

    logic signBit;                          // instr[31] is the sign in every format

    assign signBit = instr[31];

    always_comb begin
        case (immSel)
            ImmI: begin
                imm = {{20{signBit}}, instr[31:20]}; // shamt uses low 5 bits only
            end
            ImmS: begin
                imm = {{20{signBit}}, instr[31:25], instr[11:7]};
            end
            ImmB: begin
                imm = {{19{signBit}}, signBit, instr[7], instr[30:25],
                       instr[11:8], 1'b0};  // halfword offset
            end
            ImmU: begin
                imm = {instr[31:12], 12'b0}; // upper 20 bits
            end
            ImmJ: begin
                imm = {{11{signBit}}, signBit, instr[19:12], instr[20],
                       instr[30:21], 1'b0};
            end
            default: begin
                imm = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- design/regFile.sv
`timescale 1ns/100ps
`default_nettype none

module regFile #(
    parameter int NumRegs = 32              // 16 for an rv32e sized file
) (
    input  logic        clk,
    input  logic        arstN,
    input  logic [4:0]  rs1Addr,
    input  logic [4:0]  rs2Addr,
    input  logic [4:0]  rdAddr,
    input  logic        rdWe,
    input  rvPkg::wordT rdData,
    output rvPkg::wordT rs1Data,
    output rvPkg::wordT rs2Data
);
    import rvPkg::*;

    wordT regs [NumRegs];

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < NumRegs; i++) begin
                regs[i] <= '0;
            end
        end else if (rdWe && rdAddr != 5'd0 && int'(rdAddr) < NumRegs) begin
            regs[rdAddr] <= rdData;         // x0 never written
        end
    end

    // x0 and unimplemented registers read as zero
    assign rs1Data = (rs1Addr == 5'd0 || int'(rs1Addr) >= NumRegs) ? '0 : regs[rs1Addr];
    assign rs2Data = (rs2Addr == 5'd0 || int'(rs2Addr) >= NumRegs) ? '0 : regs[rs2Addr];

endmodule

`default_nettype wire

//--- design/aluExecute.sv
`timescale 1ns/100ps
`default_nettype none

module aluExecute (
    input  rvPkg::wordT  opA,
    input  rvPkg::wordT  opB,
    input  rvPkg::aluOpT aluOp,
    input  logic [2:0]   branchFunc,        // func3 of the branch
    output rvPkg::wordT  result,
    output logic         branchTaken
);
    import rvPkg::*;

    logic [4:0] shamt;                      // rs2[4:0] or imm[4:0]
    logic       ltSigned;
    logic       ltUnsigned;

    assign shamt      = opB[4:0];
    assign ltSigned   = $signed(opA) < $signed(opB);
    assign ltUnsigned = opA < opB;

    always_comb begin
        case (aluOp)
            AluAdd:   result = opA + opB;
            AluSub:   result = opA - opB;
            AluSll:   result = opA << shamt;
            AluSlt:   result = {31'b0, ltSigned};
            AluSltu:  result = {31'b0, ltUnsigned};
            AluXor:   result = opA ^ opB;
            AluSrl:   result = opA >> shamt;
            AluSra:   result = wordT'($signed(opA) >>> shamt); // keeps the sign
            AluOr:    result = opA | opB;
            AluAnd:   result = opA & opB;
            AluPassB: result = opB;          // lui
            default:  result = '0;
        endcase
    end

    // decoder only looks at this for branch opcodes
    always_comb begin
        case (branchFunc)
            3'b000:  branchTaken = (opA == opB);   // beq
            3'b001:  branchTaken = (opA != opB);   // bne
            3'b100:  branchTaken = ltSigned;       // blt
            3'b101:  branchTaken = !ltSigned;      // bge
            3'b110:  branchTaken = ltUnsigned;     // bltu
            3'b111:  branchTaken = !ltUnsigned;    // bgeu
            default: branchTaken = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

//--- design/loadStoreUnit.sv
`timescale 1ns/100ps
`default_nettype none

module loadStoreUnit (
    input  rvPkg::wordT addr,               // alu result
    input  rvPkg::wordT storeData,          // rs2
    input  logic [2:0]  sizeFunc,           // func3, bit 2 = unsigned load
    input  logic        memWrite,
    input  rvPkg::wordT rdata,
    output rvPkg::wordT dataWdata,
    output logic [3:0]  dataBe,
    output logic        dataWe,
    output rvPkg::wordT loadData
);
    import rvPkg::*;

    logic [1:0] byteOff;                    // byte lane within the word
    logic [3:0] beRaw;                      // enables before the write qualifier
    wordT       laneData;                   // addressed byte/half moved to bit 0

    assign byteOff = addr[1:0];
    assign dataWe  = memWrite;              // single-cycle strobe

    // store data copied to every lane so the enables pick it out
    always_comb begin
        case (sizeFunc[1:0])
            2'b00: begin                    // sb
                dataWdata = {4{storeData[7:0]}};
                beRaw     = 4'b0001 << byteOff;
            end
            2'b01: begin                    // sh
                dataWdata = {2{storeData[15:0]}};
                beRaw     = byteOff[1] ? 4'b1100 : 4'b0011;
            end
            default: begin                  // sw
                dataWdata = storeData;
                beRaw     = 4'b1111;
            end
        endcase
    end

    assign dataBe = memWrite ? beRaw : 4'b0000;

    // load side
    assign laneData = rdata >> {byteOff, 3'b000};

    always_comb begin
        case (sizeFunc)
            3'b000:  loadData = {{24{laneData[7]}}, laneData[7:0]};   // lb
            3'b001:  loadData = {{16{laneData[15]}}, laneData[15:0]}; // lh
            3'b100:  loadData = {24'b0, laneData[7:0]};               // lbu
            3'b101:  loadData = {16'b0, laneData[15:0]};              // lhu
            default: loadData = laneData;                              // lw
        endcase
    end

endmodule

`default_nettype wire

//--- design/pcUnit.sv
`timescale 1ns/100ps
`default_nettype none

module pcUnit #(
    parameter rvPkg::wordT ResetPc = '0
) (
    input  logic          clk,
    input  logic          arstN,
    input  rvPkg::pcSelT  pcSel,
    input  rvPkg::wordT   imm,
    input  rvPkg::wordT   jalrBase,         // rs1
    output rvPkg::wordT   pc,
    output rvPkg::wordT   pcPlus4
);
    import rvPkg::*;

    wordT pcNext;
    wordT pcTarget;                         // branch / jal
    wordT jalrTarget;

    assign pcPlus4    = pc + 32'd4;
    assign pcTarget   = pc + imm;
    assign jalrTarget = (jalrBase + imm) & ~32'd1; // lsb dropped per spec

    always_comb begin
        case (pcSel)
            PcTarget: pcNext = pcTarget;
            PcJalr:   pcNext = jalrTarget;
            default:  pcNext = pcPlus4;
        endcase
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            pc <= ResetPc;
        end else begin
            pc <= pcNext;                   // one instruction per cycle
        end
    end

endmodule

`default_nettype wire

//--- design/rvCore.sv
`timescale 1ns/100ps
`default_nettype none

module rvCore #(
    parameter int          NumRegs = 32,
    parameter rvPkg::wordT ResetPc = '0
) (
    input  logic        clk,
    input  logic        arstN,
    input  rvPkg::wordT instr,              // returns combinationally from instrAddr
    output rvPkg::wordT instrAddr,
    output rvPkg::wordT dataAddr,
    output rvPkg::wordT dataWdata,
    output logic [3:0]  dataBe,
    output logic        dataWe,
    input  rvPkg::wordT dataRdata,
    output logic        retireValid,
    output rvPkg::wordT retirePc,
    output logic        rdWe,
    output logic [4:0]  rdAddr,
    output rvPkg::wordT rdData
);
    import rvPkg::*;

    logic      regWrite;
    logic      memWrite;
    aluOpT     aluOp;
    logic      aluSrcImm;
    logic      aluSrcPc;
    immSelT    immSel;
    resultSelT resultSel;
    pcSelT     pcSel;
    logic      branchTaken;
    logic [2:0] func3;                      // branch kind and access size
    wordT      imm;
    wordT      rs1Data;
    wordT      rs2Data;
    wordT      opA;
    wordT      opB;
    wordT      aluResult;
    wordT      loadData;
    wordT      pc;
    wordT      pcPlus4;

    assign func3 = instr[14:12];

    // decode
    controlDecoder decoder_i (
        .instr(instr), .branchTaken(branchTaken), .regWrite(regWrite),
        .memWrite(memWrite), .aluOp(aluOp), .aluSrcImm(aluSrcImm),
        .aluSrcPc(aluSrcPc), .immSel(immSel), .resultSel(resultSel), .pcSel(pcSel)
    );

    immExtend immExtend_i (.instr(instr), .immSel(immSel), .imm(imm));

    regFile #(.NumRegs(NumRegs)) regFile_i (
        .clk(clk), .arstN(arstN), .rs1Addr(instr[19:15]), .rs2Addr(instr[24:20]),
        .rdAddr(rdAddr), .rdWe(rdWe), .rdData(rdData),
        .rs1Data(rs1Data), .rs2Data(rs2Data)
    );

    // execute
    assign opA = aluSrcPc ? pc : rs1Data;   // pc only for auipc
    assign opB = aluSrcImm ? imm : rs2Data;

    aluExecute alu_i (
        .opA(opA), .opB(opB), .aluOp(aluOp), .branchFunc(func3),
        .result(aluResult), .branchTaken(branchTaken)
    );

    // result
    loadStoreUnit lsu_i (
        .addr(aluResult), .storeData(rs2Data), .sizeFunc(func3), .memWrite(memWrite),
        .rdata(dataRdata), .dataWdata(dataWdata), .dataBe(dataBe), .dataWe(dataWe),
        .loadData(loadData)
    );

    pcUnit #(.ResetPc(ResetPc)) pcUnit_i (
        .clk(clk), .arstN(arstN), .pcSel(pcSel), .imm(imm), .jalrBase(rs1Data),
        .pc(pc), .pcPlus4(pcPlus4)
    );

    // writeback select
    always_comb begin
        case (resultSel)
            ResLoad:    rdData = loadData;
            ResPcPlus4: rdData = pcPlus4;   // jal / jalr link
            default:    rdData = aluResult;
        endcase
    end

    assign rdWe      = regWrite;
    assign rdAddr    = instr[11:7];
    assign dataAddr  = aluResult;           // rs1 + imm for loads and stores
    assign instrAddr = pc;
    assign retirePc  = pc;
    assign retireValid = arstN;             // every cycle out of reset retires one instr

endmodule

`default_nettype wire

//--- sim/rvCore_assertions.sv
`timescale 1ns/100ps
`default_nettype none

module rvCoreAssertions (
    input logic        clk,
    input logic        arstN,
    input logic        dataWe,
    input logic [3:0]  dataBe,
    input logic        rdWe,
    input logic [4:0]  rdAddr,
    input rvPkg::wordT rdData,
    input rvPkg::wordT instrAddr
);
    import rvPkg::*;

    int unsigned assertFails = 0;           // failed assertion count

    // a store always touches at least one byte
    storeHasEnables: assert property (@(posedge clk) disable iff (!arstN)
        dataWe |-> dataBe != 4'b0000)
        else begin
            $error("store strobe without byte enables");
            assertFails++;
        end

    // only writes to x0 may carry unknown data
    rdWriteKnown: assert property (@(posedge clk) disable iff (!arstN)
        rdWe && rdAddr != 5'd0 |-> !$isunknown(rdData))
        else begin
            $error("register write with unknown data");
            assertFails++;
        end

    fetchAligned: assert property (@(posedge clk) disable iff (!arstN)
        instrAddr[1:0] == 2'b00)
        else begin
            $error("fetch address not word aligned");
            assertFails++;
        end

endmodule

bind rvCore rvCoreAssertions assertions_i (
    .clk(clk), .arstN(arstN), .dataWe(dataWe), .dataBe(dataBe),
    .rdWe(rdWe), .rdAddr(rdAddr), .rdData(rdData), .instrAddr(instrAddr)
);

`default_nettype wire

//--- sim/rvRefModel.svh
`ifndef RV_REF_MODEL_SVH
`define RV_REF_MODEL_SVH

wordT       mRegs [32];                     // architectural registers
wordT       mMem [64];                      // 256-byte data window
wordT       mPc;
logic       expWe, expSt, expLd;            // expected strobes for the current instr
logic [3:0] expBe;
logic [4:0] expRdAddr;
wordT       expRd, expAddr, expWdata;

task automatic resetModel();
    for (int i = 0; i < 32; i++) begin
        mRegs[i] = '0;
    end
    mPc = ResetPc;
endtask

function automatic wordT computeAlu(logic [2:0] f3, logic alt, wordT a, wordT b);
    case (f3)
        3'd0:    return alt ? a - b : a + b;
        3'd1:    return a << b[4:0];
        3'd2:    return {31'b0, $signed(a) < $signed(b)};
        3'd3:    return {31'b0, a < b};
        3'd4:    return a ^ b;
        3'd5:    return alt ? wordT'($signed(a) >>> b[4:0]) : a >> b[4:0];
        3'd6:    return a | b;
        default: return a & b;
    endcase
endfunction

// one architectural step that sets the exp* values and advances the state
task automatic stepModel(input wordT ins);
    wordT       rs1v, rs2v, immI, immS, immB, immU, immJ, lane, val, nextPc;
    logic [2:0] f3;
    logic       taken;
    f3     = ins[14:12];
    rs1v   = mRegs[ins[19:15]];
    rs2v   = mRegs[ins[24:20]];
    immI   = {{20{ins[31]}}, ins[31:20]};
    immS   = {{20{ins[31]}}, ins[31:25], ins[11:7]};
    immB   = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
    immU   = {ins[31:12], 12'b0};
    immJ   = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
    {expWe, expSt, expLd, expBe, expAddr, expWdata, val} = '0;
    expRdAddr = ins[11:7];
    nextPc = mPc + 32'd4;
    case (ins[6:0])
        7'h13: begin
            expWe = 1'b1;
            val   = computeAlu(f3, ins[30] && f3 == 3'd5, rs1v, immI); // no subi
        end
        7'h33: begin
            expWe = 1'b1;
            val   = computeAlu(f3, ins[30], rs1v, rs2v);
        end
        7'h37: begin
            expWe = 1'b1;
            val   = immU;
        end
        7'h17: begin
            expWe = 1'b1;
            val   = mPc + immU;             // no redirect
        end
        7'h63: begin
            case (f3)
                3'd0:    taken = rs1v == rs2v;
                3'd1:    taken = rs1v != rs2v;
                3'd4:    taken = $signed(rs1v) < $signed(rs2v);
                3'd5:    taken = $signed(rs1v) >= $signed(rs2v);
                3'd6:    taken = rs1v < rs2v;
                3'd7:    taken = rs1v >= rs2v;
                default: taken = 1'b0;
            endcase
            if (taken) begin
                nextPc = mPc + immB;
            end
        end
        7'h6f: begin
            expWe  = 1'b1;
            val    = mPc + 32'd4;
            nextPc = mPc + immJ;
        end
        7'h67: begin
            expWe  = 1'b1;
            val    = mPc + 32'd4;
            nextPc = (rs1v + immI) & ~32'd1;
        end
        7'h03: begin
            expWe   = 1'b1;
            expLd   = 1'b1;
            expAddr = rs1v + immI;
            lane    = mMem[expAddr[7:2]] >> (8 * expAddr[1:0]);
            case (f3)
                3'd0:    val = {{24{lane[7]}}, lane[7:0]};
                3'd1:    val = {{16{lane[15]}}, lane[15:0]};
                3'd4:    val = {24'b0, lane[7:0]};
                3'd5:    val = {16'b0, lane[15:0]};
                default: val = lane;
            endcase
        end
        7'h23: begin
            expSt   = 1'b1;
            expAddr = rs1v + immS;
            case (f3[1:0])
                2'd0: begin
                    expWdata = {4{rs2v[7:0]}};
                    expBe    = 4'b0001 << expAddr[1:0];
                end
                2'd1: begin
                    expWdata = {2{rs2v[15:0]}};
                    expBe    = expAddr[1] ? 4'b1100 : 4'b0011;
                end
                default: begin
                    expWdata = rs2v;
                    expBe    = 4'b1111;
                end
            endcase
            for (int b = 0; b < 4; b++) begin
                if (expBe[b]) begin
                    mMem[expAddr[7:2]][8*b +: 8] = expWdata[8*b +: 8];
                end
            end
        end
        default: begin                      // unknown opcode retires as a no-op
        end
    endcase
    expRd = val;
    if (expWe && ins[11:7] != 5'd0) begin
        mRegs[ins[11:7]] = val;
    end
    mPc = nextPc;
endtask

`endif

//--- sim/rvCoreTb.sv
`timescale 1ns/100ps
`default_nettype none

module rvCoreTb;
    import rvPkg::*;

    localparam int   ProgWords = 256;       // program fits in 1 KiB
    localparam wordT ResetPc   = '0;

    logic       clk, arstN, dataWe, retireValid, rdWe;
    logic [3:0] dataBe;
    logic [4:0] rdAddr;
    wordT       instr, instrAddr, dataAddr, dataWdata, dataRdata, retirePc, rdData;
    wordT       imem [ProgWords];
    wordT       dmem [64];
    int         errCount, testCount, failCount;
    string      curTest;

    `include "rvRefModel.svh"

    rvCore #(.NumRegs(32), .ResetPc(ResetPc)) dut_i (
        .clk(clk), .arstN(arstN), .instr(instr), .instrAddr(instrAddr),
        .dataAddr(dataAddr), .dataWdata(dataWdata), .dataBe(dataBe), .dataWe(dataWe),
        .dataRdata(dataRdata), .retireValid(retireValid), .retirePc(retirePc),
        .rdWe(rdWe), .rdAddr(rdAddr), .rdData(rdData)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin             // data memory write port
        if (dataWe) begin
            for (int b = 0; b < 4; b++) begin
                if (dataBe[b]) begin
                    dmem[dataAddr[7:2]][8*b +: 8] <= dataWdata[8*b +: 8];
                end
            end
        end
    end

    task automatic checkWord(string what, wordT exp, wordT act);
        if (exp !== act) begin
            errCount++;
            $display("CHECK FAILED %s %s: expected %h, actual %h", curTest, what, exp, act);
        end
    endtask

    task automatic checkStrobe(string what, logic [3:0] exp, logic [3:0] act);
        if (exp !== act) begin
            errCount++;
            $display("CHECK FAILED %s %s: expected %b, actual %b", curTest, what, exp, act);
        end
    endtask

    task automatic checkReg(string what, logic [4:0] exp, logic [4:0] act);
        if (exp !== act) begin
            errCount++;
            $display("CHECK FAILED %s %s: expected %0d, actual %0d", curTest, what, exp, act);
        end
    endtask

    task automatic checkFlag(string what, logic exp, logic act);
        if (exp !== act) begin
            errCount++;
            $display("CHECK FAILED %s %s: expected %b, actual %b", curTest, what, exp, act);
        end
    endtask

    // kind 0 arith, 1 upper, 2 control flow, 3 memory, 4 any
    function automatic wordT genInstr(int kind, int idx);
        int          k, t, sz;
        logic [4:0]  rd, rs1, rs2;
        logic [2:0]  f3;
        logic [11:0] imm;
        logic [19:0] upper;
        logic [12:0] boff;
        logic [20:0] joff;
        k     = (kind == 4) ? int'($urandom % 4) : (($urandom % 2) ? 0 : kind);
        rd    = 5'($urandom);
        rs1   = 5'($urandom);
        rs2   = 5'($urandom);
        f3    = 3'($urandom);
        imm   = 12'($urandom);
        upper = 20'($urandom);
        t     = $urandom % (ProgWords - 1);
        if (t == idx) begin
            t = idx + 1;                    // no self loops
        end
        boff = 13'((t - idx) * 4);
        joff = 21'((t - idx) * 4);
        if (k == 0) begin
            if ($urandom % 2) begin
                if (f3 == 3'd1) imm = {7'b0, imm[4:0]};
                if (f3 == 3'd5) imm = {1'b0, imm[10], 5'b0, imm[4:0]}; // srli / srai
                return {imm, rs1, f3, rd, 7'h13};
            end
            return {1'b0, (f3 == 3'd0 || f3 == 3'd5) ? imm[10] : 1'b0, 5'b0,
                    rs2, rs1, f3, rd, 7'h33};
        end else if (k == 1) begin
            return {upper, rd, imm[0] ? 7'h37 : 7'h17};
        end else if (k == 2) begin
            sz = $urandom % 3;
            if (sz == 0) begin
                sz = $urandom % 6;
                f3 = (sz < 2) ? 3'(sz) : 3'(sz + 2);
                return {boff[12], boff[10:5], rs2, rs1, f3, boff[4:1], boff[11], 7'h63};
            end
            if (sz == 1) return {joff[20], joff[10:1], joff[11], joff[19:12], rd, 7'h6f};
            return {12'(t * 4), 5'd0, 3'd0, rd, 7'h67}; // jalr from x0
        end
        sz  = $urandom % 3;
        imm = 12'h100 + 12'(($urandom % 256) & ~((1 << sz) - 1)); // aligned in window
        if ($urandom % 2) return {imm[11:5], rs2, 5'd0, 3'(sz), imm[4:0], 7'h23};
        f3 = 3'(sz) | ((sz < 2 && ($urandom % 2)) ? 3'b100 : 3'b000);
        return {imm, 5'd0, f3, rd, 7'h03};
    endfunction

    task automatic loadProgram(int kind);
        logic [20:0] back;
        back    = 21'(-(ProgWords - 1) * 4);
        imem[0] = '0;                       // no-op at the reset address
        for (int i = 1; i < ProgWords - 1; i++) begin
            imem[i] = genInstr(kind, i);
        end
        imem[ProgWords-1] = {back[20], back[10:1], back[11], back[19:12], 5'd0, 7'h6f};
        for (int i = 0; i < 64; i++) begin
            dmem[i] = (32'h9e3779b9 * (i + 1)) ^ (i << 20);
            mMem[i] = dmem[i];
        end
        resetModel();
    endtask

    task automatic resetDut();
        int waitCnt;
        @(negedge clk);
        arstN     = 1'b0;
        instr     = imem[0];
        dataRdata = '0;
        repeat (2) @(negedge clk);
        checkWord("retirePc", ResetPc, retirePc);
        checkFlag("rdWe", 1'b0, rdWe);
        checkFlag("dataWe", 1'b0, dataWe);
        checkFlag("retireValid", 1'b0, retireValid);
        arstN   = 1'b1;
        waitCnt = 0;
        while (!retireValid && waitCnt < 10) begin
            #1;
            waitCnt++;
        end
        if (!retireValid) begin
            errCount++;
            $display("%s: retireValid did not rise after reset", curTest);
        end
    endtask

    task automatic runCycles(int n);
        for (int c = 0; c < n; c++) begin
            instr = imem[instrAddr[9:2]];   // combinational fetch
            #1;
            dataRdata = dmem[dataAddr[7:2]];
            #1;
            checkWord("instrAddr", mPc, instrAddr);
            checkWord("retirePc", mPc, retirePc);
            stepModel(instr);
            checkFlag("rdWe", expWe, rdWe);
            if (expWe) begin
                checkReg("rdAddr", expRdAddr, rdAddr);
                checkWord("rdData", expRd, rdData);
            end
            checkFlag("dataWe", expSt, dataWe);
            if (expSt) begin
                checkStrobe("dataBe", expBe, dataBe);
                checkWord("dataWdata", expWdata, dataWdata);
            end
            if (expSt || expLd) begin
                checkWord("dataAddr", expAddr, dataAddr);
            end
            @(negedge clk);
        end
        instr = '0;                         // idle on a no-op until the next reset
    endtask

    task automatic runTest(string name, int kind, int cycles);
        int errBefore;
        errBefore = errCount;
        curTest   = name;
        loadProgram(kind);
        resetDut();
        runCycles(cycles);
        testCount++;
        if (errCount == errBefore) begin
            $display("test %s: ok, %0d cycles", name, cycles);
        end else begin
            failCount++;
            $display("test %s: %0d mismatches", name, errCount - errBefore);
        end
    endtask

    initial begin
        clk       = 1'b0;
        arstN     = 1'b0;
        instr     = '0;
        dataRdata = '0;
        errCount  = 0;
        testCount = 0;
        failCount = 0;
        void'($urandom(70));
        runTest("reset", 4, 0);
        runTest("arith", 0, 300);
        runTest("upper", 1, 300);
        runTest("control", 2, 300);
        runTest("memory", 3, 300);
        runTest("mixed", 4, 2000);
        if (dut_i.assertions_i.assertFails != 0) begin
            $display("%0d assertion failures on the core ports",
                     dut_i.assertions_i.assertFails);
            errCount += int'(dut_i.assertions_i.assertFails);
        end
        $display("%0d tests, %0d failed, %0d mismatches", testCount, failCount, errCount);
        if (errCount == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

    initial begin                           // watchdog
        #1ms;
        $display("simulation timed out");
        $display("Testbench failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- build.f
+incdir+sim
design/rvPkg.sv
design/controlDecoder.sv
design/immExtend.sv
design/regFile.sv
design/aluExecute.sv
design/loadStoreUnit.sv
design/pcUnit.sv
design/rvCore.sv
sim/rvCore_assertions.sv
sim/rvCoreTb.sv

//--- Bender.yml
package:
  name: rvCore

sources:
  - design/rvPkg.sv
  - design/controlDecoder.sv
  - design/immExtend.sv
  - design/regFile.sv
  - design/aluExecute.sv
  - design/loadStoreUnit.sv
  - design/pcUnit.sv
  - design/rvCore.sv
  - target: simulation
    include_dirs:
      - sim
    files:
      - sim/rvCore_assertions.sv
      - sim/rvCoreTb.sv
